/* hw/panel_pkg.sv */
/* panel geometry, pixel format and pin bundles for the HUB75 driver,
   shared by the RTL and the testbench through scoped names */
package panel_pkg;

    // 16 x 16 panel split into two halves that scan together
    localparam int panel_columns = 16;
    localparam int half_rows     = 8;
    localparam int plane_count   = 4;   // bits per colour channel
    localparam int bank_depth    = half_rows * panel_columns;

    typedef logic [3:0] column_t;
    typedef logic [2:0] row_t;        // row within a half, also the panel address pins
    typedef logic [3:0] panel_row_t;  // msb picks the bottom half
    typedef logic [1:0] plane_t;
    typedef logic [3:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } pixel_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_t;

    typedef logic [plane_count-1:0] plane_mask_t;

    // pixel write port, one pixel per valid cycle
    typedef struct packed {
        logic       valid;
        panel_row_t row;
        column_t    column;
        pixel_t     pixel;
    } fb_write_t;

    // everything that goes out to the panel connector
    typedef struct packed {
        rgb_t rgb_top;
        rgb_t rgb_bottom;
        row_t row_addr;
        logic clk_pixel;
        logic latch;
        logic oe_n;       // active low output enable
    } hub75_pins_t;

endpackage

/* hw/scan_pkg.sv */
/* scan timing constants and the scan state encoding,
   used by the scan counters and the scan FSM */
package scan_pkg;

    // two cycles per column plus two for the read and slice pipeline
    localparam int shift_cycles = 2 * panel_pkg::panel_columns + 2;

    typedef logic [5:0] dwell_t;
    typedef logic [5:0] shift_count_t;

    // plane p is shown for dwell_unit << p cycles
    localparam dwell_t dwell_unit = 6'd4;

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_latch,
        st_display
    } scan_state_t;

endpackage

/* hw/scan_counters.sv */
/* counters behind the scan: shift position, dwell time, bit plane and row.
   the scan FSM runs them through shift_run, dwell_run and step_next */
`timescale 1ns/1ps

module scan_counters (
    input  logic                clk_root,
    input  logic                reset,
    input  logic                shift_run,
    input  logic                dwell_run,
    input  logic                step_next,
    output panel_pkg::column_t  column,
    output panel_pkg::row_t     row,
    output panel_pkg::plane_t   plane,
    output logic                shift_phase,
    output logic                shift_done,
    output logic                dwell_done
);

    scan_pkg::shift_count_t shift_count;
    scan_pkg::dwell_t       dwell_count;
    scan_pkg::dwell_t       dwell_limit;   // display length of the plane just latched

    always_ff @(posedge clk_root) begin
        if (reset) begin
            shift_count <= '0;
        end else if (step_next) begin
            shift_count <= '0;
        end else if (shift_run) begin
            shift_count <= shift_count + 1'b1;
        end
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            dwell_count <= '0;
            dwell_limit <= scan_pkg::dwell_unit;
        end else if (step_next) begin
            dwell_count <= '0;
            // plane still holds the one being latched here
            dwell_limit <= scan_pkg::dwell_unit << plane;
        end else if (dwell_run) begin
            dwell_count <= dwell_count + 1'b1;
        end
    end

    // plane is the inner loop, row steps when it wraps
    always_ff @(posedge clk_root) begin
        if (reset) begin
            plane <= '0;
            row   <= '0;
        end else if (step_next) begin
            if (plane == panel_pkg::plane_t'(panel_pkg::plane_count - 1)) begin
                plane <= '0;
                if (row == panel_pkg::row_t'(panel_pkg::half_rows - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                plane <= plane + 1'b1;
            end
        end
    end

    assign column = shift_count[4:1];   // each column held for two cycles

    // even nonzero counts: the data for a column sits on the pins one cycle
    // later, and the FSM register puts the clock edge on its second cycle
    assign shift_phase = shift_run && !shift_count[0] && (shift_count != '0);

    assign shift_done = shift_run &&
        (shift_count == scan_pkg::shift_count_t'(scan_pkg::shift_cycles - 1));
    assign dwell_done = dwell_run && (dwell_count == dwell_limit - 1'b1);

endmodule

/* hw/scan_fsm.sv */
/* scan sequencer: shift a row, latch it, then display it for the plane dwell.
   owns the registered panel control pins */
`timescale 1ns/1ps

module scan_fsm (
    input  logic             clk_root,
    input  logic             reset,
    input  logic             shift_done,
    input  logic             dwell_done,
    input  logic             shift_phase,
    input  panel_pkg::row_t  row,
    output logic             shift_run,
    output logic             dwell_run,
    output logic             step_next,
    output logic             clk_pixel,
    output logic             latch,
    output logic             oe_n,
    output panel_pkg::row_t  row_addr
);

    scan_pkg::scan_state_t state;
    scan_pkg::scan_state_t state_next;

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state <= scan_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            scan_pkg::st_idle: begin
                state_next = scan_pkg::st_shift;
            end
            scan_pkg::st_shift: begin
                if (shift_done) begin
                    state_next = scan_pkg::st_latch;
                end
            end
            scan_pkg::st_latch: begin
                state_next = scan_pkg::st_display;   // latch is always one cycle
            end
            scan_pkg::st_display: begin
                if (dwell_done) begin
                    state_next = scan_pkg::st_shift;
                end
            end
            default: begin
                state_next = scan_pkg::st_idle;
            end
        endcase
    end

    // counter controls follow the current state
    assign shift_run = (state == scan_pkg::st_shift);
    assign dwell_run = (state == scan_pkg::st_display);
    assign step_next = (state == scan_pkg::st_latch);

    /* pins are decoded from the next state and registered, so they line up
       with the state cycle and carry no decode glitches */
    always_ff @(posedge clk_root) begin
        if (reset) begin
            clk_pixel <= 1'b0;
            latch     <= 1'b0;
            oe_n      <= 1'b1;
            row_addr  <= '0;
        end else begin
            clk_pixel <= shift_phase;
            latch     <= (state_next == scan_pkg::st_latch);
            oe_n      <= (state_next != scan_pkg::st_display);   // blank outside display
            if (state_next == scan_pkg::st_latch) begin
                row_addr <= row;   // row that was just shifted in
            end
        end
    end

endmodule

/* hw/framebuffer.sv */
/* pixel memory in two banks, one per half panel. written one pixel at a time,
   read as a top/bottom pair at the same row and column one cycle later */
`timescale 1ns/1ps

module framebuffer (
    input  logic                 clk_root,
    input  panel_pkg::fb_write_t fb_write,
    input  panel_pkg::row_t      row,
    input  panel_pkg::column_t   column,
    output panel_pkg::pixel_t    pixel_top,
    output panel_pkg::pixel_t    pixel_bottom
);

    panel_pkg::pixel_t mem      [2][panel_pkg::bank_depth];
    panel_pkg::pixel_t rd_pixel [2];

    logic [6:0] wr_addr;
    logic [6:0] rd_addr;
    logic       wr_bank;

    assign wr_bank = fb_write.row[3];                    // bottom half goes to bank 1
    assign wr_addr = {fb_write.row[2:0], fb_write.column};
    assign rd_addr = {row, column};

    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk_root) begin
            if (fb_write.valid && (wr_bank == 1'(b))) begin
                mem[b][wr_addr] <= fb_write.pixel;
            end
            rd_pixel[b] <= mem[b][rd_addr];   // read before write on a collision
        end
    end

    assign pixel_top    = rd_pixel[0];
    assign pixel_bottom = rd_pixel[1];

endmodule

/* hw/pixel_slicer.sv */
/* takes the current bit plane out of each colour channel for the top and
   bottom pixels, masks it with the colour and brightness enables, registers it */
`timescale 1ns/1ps

module pixel_slicer (
    input  logic                   clk_root,
    input  logic                   reset,
    input  panel_pkg::pixel_t      pixel_top,
    input  panel_pkg::pixel_t      pixel_bottom,
    input  panel_pkg::plane_t      plane,
    input  panel_pkg::rgb_t        rgb_enable,
    input  panel_pkg::plane_mask_t brightness_enable,
    output panel_pkg::rgb_t        rgb_top,
    output panel_pkg::rgb_t        rgb_bottom
);

    panel_pkg::rgb_t slice_top;
    panel_pkg::rgb_t slice_bottom;
    logic            plane_on;

    // one plane bit per channel, in pin order
    function automatic panel_pkg::rgb_t plane_bits(
        input panel_pkg::pixel_t px,
        input panel_pkg::plane_t pl
    );
        panel_pkg::rgb_t bits;
        bits[0] = px.red[pl];
        bits[1] = px.green[pl];
        bits[2] = px.blue[pl];
        return bits;
    endfunction

    assign plane_on = brightness_enable[plane];   // whole plane can be switched off

    assign slice_top    = plane_bits(pixel_top, plane) & rgb_enable & {3{plane_on}};
    assign slice_bottom = plane_bits(pixel_bottom, plane) & rgb_enable & {3{plane_on}};

    always_ff @(posedge clk_root) begin
        if (reset) begin
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            rgb_top    <= slice_top;
            rgb_bottom <= slice_bottom;
        end
    end

endmodule

/* hw/hub75_top.sv */
/* HUB75 panel driver top: pixel write port in, panel pins out.
   colour and brightness enables are plain levels sampled every cycle */
`timescale 1ns/1ps

module hub75_top (
    input  logic                   clk_root,
    input  logic                   reset,
    input  panel_pkg::fb_write_t   fb_write,
    input  panel_pkg::rgb_t        rgb_enable,
    input  panel_pkg::plane_mask_t brightness_enable,
    output panel_pkg::hub75_pins_t panel
);

    // scan control
    logic shift_run;
    logic dwell_run;
    logic step_next;
    logic shift_phase;
    logic shift_done;
    logic dwell_done;

    panel_pkg::column_t column;
    panel_pkg::row_t    row;
    panel_pkg::plane_t  plane;

    // pixel path
    panel_pkg::pixel_t pixel_top;
    panel_pkg::pixel_t pixel_bottom;
    panel_pkg::rgb_t   rgb_top;
    panel_pkg::rgb_t   rgb_bottom;

    // panel control pins
    logic              clk_pixel;
    logic              latch;
    logic              oe_n;
    panel_pkg::row_t   row_addr;

    scan_fsm u_scan_fsm (
        .clk_root    (clk_root),
        .reset       (reset),
        .shift_done  (shift_done),
        .dwell_done  (dwell_done),
        .shift_phase (shift_phase),
        .row         (row),
        .shift_run   (shift_run),
        .dwell_run   (dwell_run),
        .step_next   (step_next),
        .clk_pixel   (clk_pixel),
        .latch       (latch),
        .oe_n        (oe_n),
        .row_addr    (row_addr)
    );

    scan_counters u_scan_counters (
        .clk_root    (clk_root),
        .reset       (reset),
        .shift_run   (shift_run),
        .dwell_run   (dwell_run),
        .step_next   (step_next),
        .column      (column),
        .row         (row),
        .plane       (plane),
        .shift_phase (shift_phase),
        .shift_done  (shift_done),
        .dwell_done  (dwell_done)
    );

    framebuffer u_framebuffer (
        .clk_root     (clk_root),
        .fb_write     (fb_write),
        .row          (row),
        .column       (column),
        .pixel_top    (pixel_top),
        .pixel_bottom (pixel_bottom)
    );

    pixel_slicer u_pixel_slicer (
        .clk_root          (clk_root),
        .reset             (reset),
        .pixel_top         (pixel_top),
        .pixel_bottom      (pixel_bottom),
        .plane             (plane),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom)
    );

    assign panel = '{
        rgb_top:    rgb_top,
        rgb_bottom: rgb_bottom,
        row_addr:   row_addr,
        clk_pixel:  clk_pixel,
        latch:      latch,
        oe_n:       oe_n
    };

endmodule

/* dv/tb_hub75_top.sv */
/* directed testbench for the HUB75 driver. keeps a pixel model of the panel,
   watches the panel pins every cycle and checks scan order, dwell and pixel data */
`timescale 1ns/1ps

module tb_hub75_top;

    localparam int cycle_limit = 22400;   // 14 frames of 1600 cycles
    localparam int frame_cycles = 1600;
    localparam int dwell_base = 4;        // display cycles of plane 0

    logic                   clk_root;
    logic                   reset;
    panel_pkg::fb_write_t   fb_write;
    panel_pkg::rgb_t        rgb_enable;
    panel_pkg::plane_mask_t brightness_enable;
    panel_pkg::hub75_pins_t panel;

    panel_pkg::pixel_t model [16][16];    // [panel row][column]
    logic [31:0]       lfsr_state;

    // monitor state
    panel_pkg::rgb_t   cap_top [16];
    panel_pkg::rgb_t   cap_bottom [16];
    int                edge_count = 0;
    int                low_cycles = 0;
    int                frame_count = 0;
    int                cycle_count = 0;
    logic              check_data;
    logic              prev_clk_pixel;
    panel_pkg::row_t   exp_row;
    panel_pkg::plane_t exp_plane;
    panel_pkg::plane_t dwell_plane;       // plane whose display comes next

    hub75_top u_hub75_top (
        .clk_root          (clk_root),
        .reset             (reset),
        .fb_write          (fb_write),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .panel             (panel)
    );

    initial begin
        clk_root = 1'b0;
        forever #10 clk_root = ~clk_root;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else
            fail_run($sformatf("Mismatch %s: expected 0x%h got 0x%h", name, want, got));
    endtask

    // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // what the panel should see for one pixel at one plane
    function automatic panel_pkg::rgb_t expect_bits(input panel_pkg::pixel_t px, input int p);
        panel_pkg::rgb_t bits;
        bits[0] = px.red[p];
        bits[1] = px.green[p];
        bits[2] = px.blue[p];
        for (int i = 0; i < 3; i++) begin
            if (!rgb_enable[i] || !brightness_enable[p]) begin
                bits[i] = 1'b0;
            end
        end
        return bits;
    endfunction

    task automatic check_row_data();
        panel_pkg::rgb_t want_top;
        panel_pkg::rgb_t want_bottom;
        for (int c = 0; c < 16; c++) begin
            want_top = expect_bits(model[int'(exp_row)][c], exp_plane);
            want_bottom = expect_bits(model[int'(exp_row) + 8][c], exp_plane);
            check_value($sformatf("rgb_top row %0d column %0d plane %0d", exp_row, c, exp_plane),
                        cap_top[c], want_top);
            check_value($sformatf("rgb_bottom row %0d column %0d plane %0d",
                                  int'(exp_row) + 8, c, exp_plane),
                        cap_bottom[c], want_bottom);
        end
    endtask

    always @(posedge clk_root) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run("Timeout: the tests did not finish within 14 frames");
        end
    end

    // pin monitor on the falling edge
    always @(negedge clk_root) begin
        if (reset) begin
            edge_count = 0;
            low_cycles = 0;
            exp_row = '0;
            exp_plane = '0;
            dwell_plane = '0;
            prev_clk_pixel = 1'b0;
        end else begin
            if (panel.clk_pixel && !prev_clk_pixel) begin
                assert (edge_count < 16) else
                    fail_run("More than 16 pixel clock edges in one row step");
                cap_top[edge_count] = panel.rgb_top;
                cap_bottom[edge_count] = panel.rgb_bottom;
                edge_count++;
            end
            prev_clk_pixel = panel.clk_pixel;
            if (panel.latch) begin
                check_value("clk_pixel edges per step", edge_count, 16);
                check_value("row_addr", panel.row_addr, exp_row);
                if (check_data) begin
                    check_row_data();
                end
                edge_count = 0;
                dwell_plane = exp_plane;
                if (exp_plane == 2'd3 && exp_row == 3'd7) begin
                    frame_count++;
                end
                if (exp_plane == 2'd3) begin
                    exp_row++;   // wraps after row 7
                end
                exp_plane++;
            end
            if (!panel.oe_n) begin
                low_cycles++;
            end else if (low_cycles != 0) begin
                check_value("oe_n low cycles", low_cycles, dwell_base << dwell_plane);
                low_cycles = 0;
            end
        end
    end

    // returns on the falling edge just after the last step of a frame
    task automatic wait_frame();
        int start;
        start = frame_count;
        wait (frame_count != start);
        @(negedge clk_root);
    endtask

    task automatic write_pixel(input int r, input int c, input panel_pkg::pixel_t px);
        @(negedge clk_root);
        fb_write = '{valid: 1'b1, row: panel_pkg::panel_row_t'(r),
                     column: panel_pkg::column_t'(c), pixel: px};
        model[r][c] = px;
    endtask

    task automatic idle_write_port();
        @(negedge clk_root);
        fb_write.valid = 1'b0;
    endtask

    task automatic check_idle_pins();
        check_value("oe_n", panel.oe_n, 1);
        check_value("clk_pixel", panel.clk_pixel, 0);
        check_value("latch", panel.latch, 0);
        check_value("rgb_top", panel.rgb_top, 0);
        check_value("rgb_bottom", panel.rgb_bottom, 0);
        check_value("row_addr", panel.row_addr, 0);
    endtask

    task automatic test_reset_state();
        reset = 1'b1;
        repeat (3) begin
            @(negedge clk_root);
            check_idle_pins();
        end
        reset = 1'b0;
        rgb_enable = '0;          // framebuffer not written yet
        brightness_enable = '0;
        @(negedge clk_root);
        check_idle_pins();   // first cycle out of reset
    endtask

    // monitor checks order, edges and dwell; here the frame length too
    task automatic test_scan_order();
        int t0;
        wait_frame();
        t0 = cycle_count;
        wait_frame();
        check_value("frame cycles", cycle_count - t0, frame_cycles);
    endtask

    task automatic test_pixel_data();
        rgb_enable = '1;
        brightness_enable = '1;
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 16; c++) begin
                write_pixel(r, c, panel_pkg::pixel_t'(random_bits(12)));
            end
        end
        idle_write_port();
        wait_frame();        // finish the frame that saw the fill
        check_data = 1'b1;
        wait_frame();
    endtask

    task automatic test_colour_enable();
        rgb_enable = 3'b001;   // red only
        wait_frame();
        rgb_enable = '1;
    endtask

    task automatic test_brightness_enable();
        brightness_enable = 4'b1000;
        wait_frame();
        brightness_enable = '1;
    endtask

    task automatic test_single_write();
        write_pixel(12, 5, ~model[12][5]);
        idle_write_port();
        wait_frame();
        wait_frame();   // full frame with the new pixel
    endtask

    initial begin
        reset = 1'b1;
        fb_write = '0;
        rgb_enable = '1;          // data path open so only reset holds rgb low
        brightness_enable = '1;
        check_data = 1'b0;
        lfsr_state = 32'h974e;
        test_reset_state();
        test_scan_order();
        test_pixel_data();
        test_colour_enable();
        test_brightness_enable();
        test_single_write();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* filelist.f */
hw/panel_pkg.sv
hw/scan_pkg.sv
hw/scan_counters.sv
hw/scan_fsm.sv
hw/framebuffer.sv
hw/pixel_slicer.sv
hw/hub75_top.sv
dv/tb_hub75_top.sv

/* Bender.yml */
package:
  name: hub75_driver

sources:
  - files:
      - hw/panel_pkg.sv
      - hw/scan_pkg.sv
      - hw/scan_counters.sv
      - hw/scan_fsm.sv
      - hw/framebuffer.sv
      - hw/pixel_slicer.sv
      - hw/hub75_top.sv

  - target: test
    files:
      - dv/tb_hub75_top.sv
